// File: verilog/xfer_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Packet switch shared types
////////////////////////////////////////////////////////////////////////////

package xfer_pkg;

    // Virtual channels and destinations share one count
    localparam int NUM_CH = 4;

    // Field widths of a switch word
    localparam int CLASS_W = 2;
    localparam int DEST_W  = 2;
    localparam int DATA_W  = 8;

    // Default depth for every FIFO in the switch
    localparam int FIFO_DEPTH_DEF = 4;

    // One switch word
    // cls picks the virtual channel and dest picks the output FIFO
    typedef struct packed {
        logic [CLASS_W-1:0] cls;
        logic [DEST_W-1:0]  dest;
        logic [DATA_W-1:0]  data;
    } xfer_word_t;

    // FIFO status flags
    // error is a single-cycle pulse on overflow or underflow
    typedef struct packed {
        logic empty;
        logic almost_empty;
        logic full;
        logic almost_full;
        logic pause;
        logic error;
    } fifo_stat_t;

endpackage

// File: verilog/fifo_sync.sv
////////////////////////////////////////////////////////////////////////////
// Synchronous FIFO with status flags
////////////////////////////////////////////////////////////////////////////

module fifo_sync #(
    parameter type T           = logic [7:0],
    parameter int  DEPTH       = 4,
    parameter int  PAUSE_LEVEL = DEPTH - 1
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 push,
    input  T                     wr_data,
    input  logic                 pop,
    output T                     rd_data,
    output logic                 rd_valid,
    output xfer_pkg::fifo_stat_t stat
);

    // Pointer and occupancy widths
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    localparam logic [AW-1:0] LAST_PTR  = AW'(DEPTH - 1);
    localparam logic [CW-1:0] FULL_CNT  = CW'(DEPTH);
    localparam logic [CW-1:0] PAUSE_CNT = CW'(PAUSE_LEVEL);
    localparam logic [CW-1:0] ONE_CNT   = CW'(1);

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;

    logic is_empty;
    logic is_full;
    logic do_push;
    logic do_pop;

    // Pointer advance with wrap at the last entry
    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        logic [AW-1:0] nxt;
        if (ptr == LAST_PTR) begin
            nxt = '0;
        end else begin
            nxt = ptr + AW'(1);
        end
        return nxt;
    endfunction

    assign is_empty = (count == '0);
    assign is_full  = (count == FULL_CNT);

    // Overflowing pushes and underflowing pops are ignored
    assign do_push = push && !is_full;
    assign do_pop  = pop && !is_empty;

    // Storage array
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Popped word is held until the next pop
    always_ff @(posedge clk) begin
        if (do_pop) begin
            rd_data <= mem[rd_ptr];
        end
    end

    // Pointers, occupancy and read strobe
    always_ff @(posedge clk) begin
        if (!reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= do_pop;
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10: begin
                    count <= count + ONE_CNT;
                end
                2'b01: begin
                    count <= count - ONE_CNT;
                end
                default: begin
                    // Both or neither leaves the count alone
                    count <= count;
                end
            endcase
        end
    end

    // Flags come straight from the occupancy
    always_comb begin
        stat.empty        = is_empty;
        stat.almost_empty = (count == ONE_CNT);
        stat.full         = is_full;
        stat.almost_full  = (count >= PAUSE_CNT);
        stat.pause        = (count >= PAUSE_CNT);
        stat.error        = (push && is_full) || (pop && is_empty);
    end

endmodule

// File: verilog/vc_sorter.sv
////////////////////////////////////////////////////////////////////////////
// Ingress sorter by traffic class
////////////////////////////////////////////////////////////////////////////

module vc_sorter (
    input  logic                                              clk,
    input  logic                                              reset,
    input  logic                                              in_valid,
    input  xfer_pkg::xfer_word_t                              in_word,
    input  xfer_pkg::fifo_stat_t [xfer_pkg::NUM_CH-1:0]       vc_stat,
    output logic                 [xfer_pkg::NUM_CH-1:0]       vc_push,
    output xfer_pkg::xfer_word_t                              vc_word,
    output logic                                              in_drop
);

    logic                 valid_q;
    xfer_pkg::xfer_word_t word_q;
    logic                 chan_full;

    // Input strobe stage
    always_ff @(posedge clk) begin
        if (!reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            word_q <= in_word;
        end
    end

    assign vc_word   = word_q;
    assign chan_full = vc_stat[word_q.cls].full;

    // One-hot push into the channel named by the class
    always_comb begin
        vc_push = '0;
        vc_push[word_q.cls] = valid_q && !chan_full;
    end

    // Word aimed at a full channel is lost
    assign in_drop = valid_q && chan_full;

endmodule

// File: verilog/vc_arbiter.sv
////////////////////////////////////////////////////////////////////////////
// Channel arbiter and destination steering
////////////////////////////////////////////////////////////////////////////

module vc_arbiter (
    input  logic                                              clk,
    input  logic                                              reset,
    input  xfer_pkg::fifo_stat_t [xfer_pkg::NUM_CH-1:0]       vc_stat,
    output logic                 [xfer_pkg::NUM_CH-1:0]       vc_pop,
    input  xfer_pkg::xfer_word_t [xfer_pkg::NUM_CH-1:0]       vc_data,
    input  logic                 [xfer_pkg::NUM_CH-1:0]       vc_valid,
    input  logic                 [xfer_pkg::NUM_CH-1:0]       out_pause,
    output logic                 [xfer_pkg::NUM_CH-1:0]       out_push,
    output xfer_pkg::xfer_word_t                              out_data
);

    logic                          pend_q;
    logic [xfer_pkg::CLASS_W-1:0]  pend_ch;
    logic                          hold_valid;
    xfer_pkg::xfer_word_t          hold_word;

    logic                          pick_valid;
    logic [xfer_pkg::CLASS_W-1:0]  pick_ch;
    logic                          issue;
    logic                          rx_valid;
    xfer_pkg::xfer_word_t          rx_word;
    logic                          cur_valid;
    xfer_pkg::xfer_word_t          cur_word;
    logic                          cur_paused;

    // Lowest-numbered non-empty channel wins
    always_comb begin
        pick_valid = 1'b0;
        pick_ch    = '0;
        for (int i = xfer_pkg::NUM_CH - 1; i >= 0; i--) begin
            if (!vc_stat[i].empty) begin
                pick_valid = 1'b1;
                pick_ch    = i[xfer_pkg::CLASS_W-1:0];
            end
        end
    end

    // Only one word in flight at a time
    assign issue = pick_valid && !pend_q && !hold_valid;

    always_comb begin
        vc_pop = '0;
        vc_pop[pick_ch] = issue;
    end

    // Returned word from the channel that was popped
    assign rx_valid = pend_q && vc_valid[pend_ch];
    assign rx_word  = vc_data[pend_ch];

    // Held word takes precedence and the two never coincide
    assign cur_valid  = hold_valid || rx_valid;
    assign cur_word   = hold_valid ? hold_word : rx_word;
    assign cur_paused = out_pause[cur_word.dest];

    always_comb begin
        out_push = '0;
        out_push[cur_word.dest] = cur_valid && !cur_paused;
    end

    assign out_data = cur_word;

    always_ff @(posedge clk) begin
        if (!reset) begin
            pend_q     <= 1'b0;
            hold_valid <= 1'b0;
        end else begin
            if (issue) begin
                pend_q <= 1'b1;
            end else if (rx_valid) begin
                pend_q <= 1'b0;
            end
            // Park while the destination is paused
            if (cur_valid) begin
                hold_valid <= cur_paused;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            pend_ch <= pick_ch;
        end
        if (cur_valid && cur_paused) begin
            hold_word <= cur_word;
        end
    end

endmodule

// File: verilog/xfer_switch.sv
////////////////////////////////////////////////////////////////////////////
// Four-channel packet switch top
////////////////////////////////////////////////////////////////////////////

module xfer_switch #(
    parameter int DEPTH       = xfer_pkg::FIFO_DEPTH_DEF,
    parameter int PAUSE_LEVEL = DEPTH / 2
) (
    input  logic                                              clk,
    input  logic                                              reset,
    input  logic                                              in_valid,
    input  xfer_pkg::xfer_word_t                              in_word,
    output logic                                              in_drop,
    input  logic                 [xfer_pkg::NUM_CH-1:0]       out_pop,
    output xfer_pkg::xfer_word_t [xfer_pkg::NUM_CH-1:0]       out_word,
    output logic                 [xfer_pkg::NUM_CH-1:0]       out_valid,
    output xfer_pkg::fifo_stat_t [xfer_pkg::NUM_CH-1:0]       out_stat
);

    // Sorter to channel FIFOs
    logic                 [xfer_pkg::NUM_CH-1:0] vc_push;
    xfer_pkg::xfer_word_t                        vc_word;
    xfer_pkg::fifo_stat_t [xfer_pkg::NUM_CH-1:0] vc_stat;

    // Channel FIFOs to arbiter
    logic                 [xfer_pkg::NUM_CH-1:0] vc_pop;
    xfer_pkg::xfer_word_t [xfer_pkg::NUM_CH-1:0] vc_data;
    logic                 [xfer_pkg::NUM_CH-1:0] vc_valid;

    // Arbiter to output FIFOs
    logic                 [xfer_pkg::NUM_CH-1:0] out_push;
    xfer_pkg::xfer_word_t                        out_data;
    logic                 [xfer_pkg::NUM_CH-1:0] out_pause;

    vc_sorter sorter (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_word  (in_word),
        .vc_stat  (vc_stat),
        .vc_push  (vc_push),
        .vc_word  (vc_word),
        .in_drop  (in_drop)
    );

    for (genvar i = 0; i < xfer_pkg::NUM_CH; i++) begin : g_vc
        fifo_sync #(
            .T           (xfer_pkg::xfer_word_t),
            .DEPTH       (DEPTH),
            .PAUSE_LEVEL (PAUSE_LEVEL)
        ) vc_fifo (
            .clk      (clk),
            .reset    (reset),
            .push     (vc_push[i]),
            .wr_data  (vc_word),
            .pop      (vc_pop[i]),
            .rd_data  (vc_data[i]),
            .rd_valid (vc_valid[i]),
            .stat     (vc_stat[i])
        );
    end

    vc_arbiter arbiter (
        .clk       (clk),
        .reset     (reset),
        .vc_stat   (vc_stat),
        .vc_pop    (vc_pop),
        .vc_data   (vc_data),
        .vc_valid  (vc_valid),
        .out_pause (out_pause),
        .out_push  (out_push),
        .out_data  (out_data)
    );

    for (genvar i = 0; i < xfer_pkg::NUM_CH; i++) begin : g_out
        fifo_sync #(
            .T           (xfer_pkg::xfer_word_t),
            .DEPTH       (DEPTH),
            .PAUSE_LEVEL (PAUSE_LEVEL)
        ) out_fifo (
            .clk      (clk),
            .reset    (reset),
            .push     (out_push[i]),
            .wr_data  (out_data),
            .pop      (out_pop[i]),
            .rd_data  (out_word[i]),
            .rd_valid (out_valid[i]),
            .stat     (out_stat[i])
        );

        assign out_pause[i] = out_stat[i].pause;
    end

endmodule

// File: test/tb_xfer_checks.svh
////////////////////////////////////////////////////////////////////////////
// Testbench checks and random source
////////////////////////////////////////////////////////////////////////////

`ifndef TB_XFER_CHECKS_SVH
`define TB_XFER_CHECKS_SVH

int          err_count     = 0;
int          timeout_count = 0;
logic        timed_out     = 1'b0;
logic [15:0] lfsr_state    = 16'd291;

// Fibonacci LFSR for x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
endfunction

// One LFSR step per bit taken
task automatic take_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_step(lfsr_state);
        v = {v[14:0], lfsr_state[0]};
    end
endtask

task automatic check_word(input string what, input xfer_pkg::xfer_word_t got,
                          input xfer_pkg::xfer_word_t exp);
    if (got !== exp) begin
        err_count++;
        $display("error %0t: %s got cls %0d dest %0d data %h, expected cls %0d dest %0d data %h",
                 $time, what, got.cls, got.dest, got.data, exp.cls, exp.dest, exp.data);
    end
endtask

task automatic check_stat(input string what, input xfer_pkg::fifo_stat_t got,
                          input xfer_pkg::fifo_stat_t exp);
    if (got !== exp) begin
        err_count++;
        $display("error %0t: %s got %b expected %b", $time, what, got, exp);
    end
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
        err_count++;
        $display("error %0t: %s got %b expected %b", $time, what, got, exp);
    end
endtask

// Stops the remaining table rows
task automatic timeout_fail(input string what);
    timeout_count++;
    timed_out = 1'b1;
    $display("timeout at %0t: %s", $time, what);
endtask

`endif

// File: test/tb_xfer_switch.sv
////////////////////////////////////////////////////////////////////////////
// Packet switch testbench
////////////////////////////////////////////////////////////////////////////

module tb_xfer_switch;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH       = 4;
    localparam int PAUSE_LEVEL = 2;
    localparam int NUM_CH      = xfer_pkg::NUM_CH;
    localparam int TIMEOUT     = 50;

    // Table row with optional word, outputs to drain and expected drop
    typedef struct packed {
        logic                 send;
        xfer_pkg::xfer_word_t word;
        logic [3:0]           pop_mask;
        logic                 drop;
    } step_t;

    logic                                        clk;
    logic                                        reset;
    logic                                        in_valid;
    xfer_pkg::xfer_word_t                        in_word;
    logic                                        in_drop;
    logic                 [NUM_CH-1:0]           out_pop;
    xfer_pkg::xfer_word_t [NUM_CH-1:0]           out_word;
    logic                 [NUM_CH-1:0]           out_valid;
    xfer_pkg::fifo_stat_t [NUM_CH-1:0]           out_stat;

    `include "tb_xfer_checks.svh"

    step_t                rows[$];
    xfer_pkg::xfer_word_t vc_m[NUM_CH][$];
    xfer_pkg::xfer_word_t ref_q[NUM_CH][$];
    logic                 hold_v;
    xfer_pkg::xfer_word_t hold_w;
    logic [NUM_CH-1:0]    err_ok;

    xfer_switch #(
        .DEPTH       (DEPTH),
        .PAUSE_LEVEL (PAUSE_LEVEL)
    ) dut0 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_word   (in_word),
        .in_drop   (in_drop),
        .out_pop   (out_pop),
        .out_word  (out_word),
        .out_valid (out_valid),
        .out_stat  (out_stat)
    );

    always #10 clk = ~clk;

    // Output error flag only allowed during a deliberate empty pop
    always @(negedge clk) begin
        if (reset) begin
            for (int d = 0; d < NUM_CH; d++) begin
                if (out_stat[d].error && !err_ok[d]) begin
                    err_count++;
                    $display("error %0t: output %0d raised its error flag", $time, d);
                end
            end
        end
    end

    // Flags expected for a given occupancy
    function automatic xfer_pkg::fifo_stat_t stat_for(input int count);
        xfer_pkg::fifo_stat_t s;
        s.empty        = (count == 0);
        s.almost_empty = (count == 1);
        s.full         = (count >= DEPTH);
        s.almost_full  = (count >= PAUSE_LEVEL);
        s.pause        = (count >= PAUSE_LEVEL);
        s.error        = 1'b0;
        return s;
    endfunction

    function automatic logic stats_match();
        logic ok;
        ok = 1'b1;
        for (int d = 0; d < NUM_CH; d++) begin
            if (out_stat[d] !== stat_for(ref_q[d].size())) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    // Reference model with one hold slot and the lowest class first
    task automatic settle_model();
        logic                 busy;
        logic                 found;
        int                   guard;
        xfer_pkg::xfer_word_t w;
        busy  = 1'b1;
        guard = 0;
        while (busy && guard < 64) begin
            guard++;
            if (hold_v) begin
                if (ref_q[hold_w.dest].size() < PAUSE_LEVEL) begin
                    ref_q[hold_w.dest].push_back(hold_w);
                    hold_v = 1'b0;
                end else begin
                    busy = 1'b0;
                end
            end else begin
                found = 1'b0;
                for (int c = 0; c < NUM_CH && !found; c++) begin
                    if (vc_m[c].size() > 0) begin
                        w     = vc_m[c].pop_front();
                        found = 1'b1;
                    end
                end
                if (!found) begin
                    busy = 1'b0;
                end else if (ref_q[w.dest].size() < PAUSE_LEVEL) begin
                    ref_q[w.dest].push_back(w);
                end else begin
                    hold_w = w;
                    hold_v = 1'b1;
                end
            end
        end
    endtask

    task automatic add_row(input logic send, input logic [1:0] cls, input logic [1:0] dest,
                           input logic [7:0] data, input logic [3:0] pop_mask,
                           input logic drop);
        step_t r;
        r.send      = send;
        r.word.cls  = cls;
        r.word.dest = dest;
        r.word.data = data;
        r.pop_mask  = pop_mask;
        r.drop      = drop;
        rows.push_back(r);
    endtask

    task automatic build_table();
        logic [15:0] r_cls;
        logic [15:0] r_dest;
        logic [15:0] r_data;
        // Random traffic with each word popped right away
        for (int i = 0; i < 12; i++) begin
            take_bits(2, r_cls);
            take_bits(2, r_dest);
            take_bits(8, r_data);
            add_row(1'b1, r_cls[1:0], r_dest[1:0], r_data[7:0], 4'b0001 << r_dest[1:0], 1'b0);
        end
        // Two fill output 2 to pause, one waits in hold, four fill channel 1
        for (int i = 0; i < 8; i++) begin
            add_row(1'b1, 2'd1, 2'd2, 8'h30 + 8'(i), 4'b0000, i == 7);
        end
        add_row(1'b0, 2'd0, 2'd0, 8'h00, 4'b0100, 1'b0);
        // Pop of an empty output
        add_row(1'b0, 2'd0, 2'd0, 8'h00, 4'b1000, 1'b0);
        // Priority with destination 0 paused
        add_row(1'b1, 2'd3, 2'd0, 8'ha0, 4'b0000, 1'b0);
        add_row(1'b1, 2'd3, 2'd0, 8'ha1, 4'b0000, 1'b0);
        add_row(1'b1, 2'd2, 2'd0, 8'hc2, 4'b0000, 1'b0);
        add_row(1'b1, 2'd1, 2'd0, 8'hc1, 4'b0000, 1'b0);
        add_row(1'b1, 2'd0, 2'd0, 8'hc0, 4'b0000, 1'b0);
        add_row(1'b0, 2'd0, 2'd0, 8'h00, 4'b0001, 1'b0);
    endtask

    task automatic send_word(input xfer_pkg::xfer_word_t w, input logic drop);
        @(posedge clk);
        in_valid <= 1'b1;
        in_word  <= w;
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
        check_bit("in_drop", in_drop, drop);
        if (!drop) begin
            vc_m[w.cls].push_back(w);
            settle_model();
        end
    endtask

    task automatic pop_empty(input int d);
        xfer_pkg::fifo_stat_t exp;
        exp       = stat_for(0);
        exp.error = 1'b1;
        err_ok[d] = 1'b1;
        @(posedge clk);
        out_pop[d] <= 1'b1;
        @(negedge clk);
        check_stat("out_stat on empty pop", out_stat[d], exp);
        @(posedge clk);
        out_pop[d] <= 1'b0;
        @(negedge clk);
        check_bit("out_valid after empty pop", out_valid[d], 1'b0);
        err_ok[d] = 1'b0;
    endtask

    task automatic drain(input int d);
        int                   n;
        xfer_pkg::xfer_word_t exp;
        while (ref_q[d].size() > 0 && !timed_out) begin
            n = 0;
            while (out_stat[d].empty && n < TIMEOUT) begin
                @(negedge clk);
                n++;
            end
            if (out_stat[d].empty) begin
                timeout_fail("an output never received its expected word");
            end else begin
                exp = ref_q[d].pop_front();
                @(posedge clk);
                out_pop[d] <= 1'b1;
                @(posedge clk);
                out_pop[d] <= 1'b0;
                n = 0;
                @(negedge clk);
                while (!out_valid[d] && n < TIMEOUT) begin
                    @(negedge clk);
                    n++;
                end
                if (!out_valid[d]) begin
                    timeout_fail("out_valid never followed a pop");
                end else begin
                    check_word("out_word", out_word[d], exp);
                    settle_model();
                end
            end
        end
    endtask

    task automatic apply_row(input step_t r);
        int n;
        if (r.send) begin
            send_word(r.word, r.drop);
        end
        for (int d = 0; d < NUM_CH; d++) begin
            if (r.pop_mask[d] && !timed_out) begin
                if (ref_q[d].size() == 0) begin
                    pop_empty(d);
                end else begin
                    drain(d);
                end
            end
        end
        n = 0;
        while (!stats_match() && n < TIMEOUT && !timed_out) begin
            @(negedge clk);
            n++;
        end
        if (!stats_match() && !timed_out) begin
            timeout_fail("output status flags never settled");
        end
        for (int d = 0; d < NUM_CH; d++) begin
            check_stat("out_stat", out_stat[d], stat_for(ref_q[d].size()));
        end
    endtask

    task automatic finish_run();
        $display("errors %0d, timeouts %0d", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    initial begin
        clk      = 1'b0;
        reset    = 1'b0;
        in_valid = 1'b0;
        in_word  = '0;
        out_pop  = '0;
        err_ok   = '0;
        hold_v   = 1'b0;
        hold_w   = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        check_bit("in_drop after reset", in_drop, 1'b0);
        for (int d = 0; d < NUM_CH; d++) begin
            check_stat("out_stat after reset", out_stat[d], stat_for(0));
            check_bit("out_valid after reset", out_valid[d], 1'b0);
        end
        build_table();
        for (int i = 0; i < rows.size() && !timed_out; i++) begin
            apply_row(rows[i]);
        end
        finish_run();
    end

endmodule

// File: vlog.f
+incdir+test
verilog/xfer_pkg.sv
verilog/fifo_sync.sv
verilog/vc_sorter.sv
verilog/vc_arbiter.sv
verilog/xfer_switch.sv
test/tb_xfer_switch.sv

// File: Bender.yml
package:
  name: xfer_switch

sources:
  - files:
      - verilog/xfer_pkg.sv
      - verilog/fifo_sync.sv
      - verilog/vc_sorter.sv
      - verilog/vc_arbiter.sv
      - verilog/xfer_switch.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_xfer_switch.sv
